/* hdl/bus_pkg.sv */
package bus_pkg;

  // arbiter states
  typedef enum logic [2:0] {
    IDLE,
    IF_BUS,
    LS_BUS,
    LS_TIMER
  } arb_state_t;

  // owner of the request in flight
  typedef enum logic {
    CLIENT_IFU,
    CLIENT_LSU
  } client_t;

  // mtime words, answered locally
  localparam logic [31:0] RTC_ADDR_LO = 32'ha000_0048;
  localparam logic [31:0] RTC_ADDR_HI = 32'ha000_004c;

  typedef logic [2:0] axi_size_t;

  localparam axi_size_t SIZE_B = 3'b000;
  localparam axi_size_t SIZE_H = 3'b001;
  localparam axi_size_t SIZE_W = 3'b010;

  typedef logic [1:0] axi_resp_t;

  localparam axi_resp_t RESP_OKAY = 2'b00;

endpackage

/* hdl/mem_req_if.sv */
`timescale 1ns/1ps

interface mem_req_if #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
);
  import bus_pkg::*;

  logic [ADDR_W-1:0]   addr;
  logic [DATA_W-1:0]   wdata;
  logic [DATA_W/8-1:0] wstrb;  // unshifted client strobe
  logic                we;
  client_t             owner;
  logic                req;    // level, held until done
  logic [DATA_W-1:0]   rdata;
  logic                done;   // one-cycle pulse

  modport arb (
    output addr, wdata, wstrb, we, owner, req,
    input  rdata, done
  );

  modport port (
    input  addr, wdata, wstrb, we, owner, req,
    output rdata, done
  );

endinterface

/* hdl/timer_rd_if.sv */
`timescale 1ns/1ps

interface timer_rd_if #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
);

  logic [ADDR_W-1:0] addr;
  logic              valid;   // single-cycle pulse
  logic [DATA_W-1:0] rdata;
  logic              rvalid;  // one cycle after valid

  modport arb (
    output addr, valid,
    input  rdata, rvalid
  );

  modport timer (
    input  addr, valid,
    output rdata, rvalid
  );

endinterface

/* hdl/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [ADDR_W-1:0]   ifu_araddr_i,
  input  logic                ifu_arvalid_i,
  output logic [DATA_W-1:0]   ifu_rdata_o,
  output logic                ifu_rvalid_o,
  input  logic [ADDR_W-1:0]   lsu_araddr_i,
  input  logic                lsu_arvalid_i,
  input  logic [DATA_W/8-1:0] lsu_rstrb_i,
  output logic [DATA_W-1:0]   lsu_rdata_o,
  output logic                lsu_rvalid_o,
  input  logic [ADDR_W-1:0]   lsu_awaddr_i,
  input  logic                lsu_awvalid_i,
  input  logic [DATA_W-1:0]   lsu_wdata_i,
  input  logic [DATA_W/8-1:0] lsu_wstrb_i,
  output logic                lsu_wready_o,
  mem_req_if.arb              req,
  timer_rd_if.arb             tmr
);
  import bus_pkg::*;

  localparam int STRB_W = DATA_W / 8;

  arb_state_t        state;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] wdata_q;
  logic [STRB_W-1:0] wstrb_q;
  logic              we_q;
  client_t           owner_q;
  logic              req_q;
  logic              tmr_valid_q;
  logic              lsu_rtc;

  assign lsu_rtc = (lsu_araddr_i == ADDR_W'(RTC_ADDR_LO)) ||
                   (lsu_araddr_i == ADDR_W'(RTC_ADDR_HI));

  // lsu first, store before load
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state       <= IDLE;
      req_q       <= 1'b0;
      tmr_valid_q <= 1'b0;
    end
    else
    begin
      tmr_valid_q <= 1'b0;
      case (state)
        IDLE:
        begin
          if (lsu_awvalid_i)
          begin
            state <= LS_BUS;
            req_q <= 1'b1;
          end
          else if (lsu_arvalid_i && lsu_rtc)
          begin
            state       <= LS_TIMER;
            tmr_valid_q <= 1'b1;
          end
          else if (lsu_arvalid_i)
          begin
            state <= LS_BUS;
            req_q <= 1'b1;
          end
          else if (ifu_arvalid_i)
          begin
            state <= IF_BUS;
            req_q <= 1'b1;
          end
        end
        IF_BUS, LS_BUS:
        begin
          if (req.done)
          begin
            state <= IDLE;
            req_q <= 1'b0;
          end
        end
        LS_TIMER:
        begin
          if (tmr.rvalid)
            state <= IDLE;
        end
        default:
          state <= IDLE;
      endcase
    end
  end

  // request copy, refreshed while idle
  always_ff @(posedge clk)
  begin
    if (state == IDLE)
    begin
      if (lsu_awvalid_i)
      begin
        addr_q  <= lsu_awaddr_i;
        wdata_q <= lsu_wdata_i;
        wstrb_q <= lsu_wstrb_i;
        we_q    <= 1'b1;
        owner_q <= CLIENT_LSU;
      end
      else if (lsu_arvalid_i)
      begin
        addr_q  <= lsu_araddr_i;
        wdata_q <= '0;
        wstrb_q <= lsu_rstrb_i;  // load strobe sets the size
        we_q    <= 1'b0;
        owner_q <= CLIENT_LSU;
      end
      else
      begin
        addr_q  <= ifu_araddr_i;
        wdata_q <= '0;
        wstrb_q <= '1;  // fetch is always a word
        we_q    <= 1'b0;
        owner_q <= CLIENT_IFU;
      end
    end
  end

  assign req.addr  = addr_q;
  assign req.wdata = wdata_q;
  assign req.wstrb = wstrb_q;
  assign req.we    = we_q;
  assign req.owner = owner_q;
  assign req.req   = req_q;

  assign tmr.addr  = addr_q;
  assign tmr.valid = tmr_valid_q;

  assign ifu_rdata_o  = req.rdata;
  assign ifu_rvalid_o = req.done && (req.owner == CLIENT_IFU);
  assign lsu_rdata_o  = tmr.rvalid ? tmr.rdata : req.rdata;
  assign lsu_rvalid_o = tmr.rvalid || (req.done && (req.owner == CLIENT_LSU) && !we_q);
  assign lsu_wready_o = req.done && (req.owner == CLIENT_LSU) && we_q;

  // the port answers only a granted request
  a_done_when_granted: assert property (
    @(posedge clk) disable iff (rst)
    !(state inside {IF_BUS, LS_BUS}) |-> !req.done
  );

  // timer and bus answers never overlap
  a_single_done: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0({ifu_rvalid_o, lsu_rvalid_o, lsu_wready_o})
  );

endmodule

/* hdl/axi_master_port.sv */
`timescale 1ns/1ps

module axi_master_port #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic               clk,
  input  logic               rst,
  mem_req_if.port            req,
  output logic [ADDR_W-1:0]  axi_araddr_o,
  output bus_pkg::axi_size_t axi_arsize_o,
  output logic               axi_arvalid_o,
  input  logic               axi_arready_i,
  output logic [3:0]         axi_arid_o,
  output logic [7:0]         axi_arlen_o,
  input  logic [63:0]        axi_rdata_i,
  input  bus_pkg::axi_resp_t axi_rresp_i,
  input  logic               axi_rvalid_i,
  output logic               axi_rready_o,
  output logic [ADDR_W-1:0]  axi_awaddr_o,
  output bus_pkg::axi_size_t axi_awsize_o,
  output logic               axi_awvalid_o,
  input  logic               axi_awready_i,
  output logic [3:0]         axi_awid_o,
  output logic [7:0]         axi_awlen_o,
  output logic [63:0]        axi_wdata_o,
  output logic [7:0]         axi_wstrb_o,
  output logic               axi_wlast_o,
  output logic               axi_wvalid_o,
  input  logic               axi_wready_i,
  input  bus_pkg::axi_resp_t axi_bresp_i,
  input  logic               axi_bvalid_i,
  output logic               axi_bready_o
);
  import bus_pkg::*;

  localparam int STRB_W = DATA_W / 8;

  typedef enum logic [1:0] {
    P_IDLE,
    P_ADDR,
    P_RESP,
    P_DONE
  } port_state_t;

  port_state_t       state;
  logic              aw_done;
  logic              w_done;
  logic              aw_ok;
  logic              w_ok;
  logic [DATA_W-1:0] wdata_sh;
  logic [STRB_W-1:0] wstrb_sh;
  logic [DATA_W-1:0] rdata_q;
  axi_size_t         size;

  always_comb
  begin
    case (req.wstrb)
      STRB_W'(1):  size = SIZE_B;
      STRB_W'(3):  size = SIZE_H;
      STRB_W'(15): size = SIZE_W;
      default:     size = SIZE_B;
    endcase
  end

  // accepted earlier or accepted now
  assign aw_ok = aw_done || (axi_awvalid_o && axi_awready_i);
  assign w_ok  = w_done || (axi_wvalid_o && axi_wready_i);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state   <= P_IDLE;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end
    else
    begin
      case (state)
        P_IDLE:
        begin
          if (req.req)
            state <= P_ADDR;
        end
        P_ADDR:
        begin
          if (req.we)
          begin
            if (aw_ok && w_ok)
            begin
              state   <= P_RESP;
              aw_done <= 1'b0;
              w_done  <= 1'b0;
            end
            else
            begin
              aw_done <= aw_ok;
              w_done  <= w_ok;
            end
          end
          else if (axi_arready_i)
            state <= P_RESP;
        end
        P_RESP:
        begin
          if (req.we ? axi_bvalid_i : axi_rvalid_i)
            state <= P_DONE;
        end
        default:
          state <= P_IDLE;  // P_DONE lasts one cycle
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == P_RESP && axi_rvalid_i)
      rdata_q <= req.addr[2] ? axi_rdata_i[63:32] : axi_rdata_i[31:0];
  end

  assign req.rdata = rdata_q;
  assign req.done  = (state == P_DONE);

  assign wdata_sh = req.wdata << {req.addr[1:0], 3'b000};
  assign wstrb_sh = req.wstrb << req.addr[1:0];

  assign axi_araddr_o  = req.addr;
  assign axi_arsize_o  = size;
  assign axi_arvalid_o = (state == P_ADDR) && !req.we;
  assign axi_arid_o    = 4'd0;
  assign axi_arlen_o   = 8'd0;
  assign axi_rready_o  = 1'b1;

  assign axi_awaddr_o  = req.addr;
  assign axi_awsize_o  = size;
  assign axi_awvalid_o = (state == P_ADDR) && req.we && !aw_done;
  assign axi_awid_o    = 4'd0;
  assign axi_awlen_o   = 8'd0;

  assign axi_wdata_o  = {wdata_sh, wdata_sh};  // both lanes carry it
  assign axi_wstrb_o  = req.addr[2] ? {wstrb_sh, {STRB_W{1'b0}}} : {{STRB_W{1'b0}}, wstrb_sh};
  assign axi_wlast_o  = axi_wvalid_o;
  assign axi_wvalid_o = (state == P_ADDR) && req.we && !w_done;
  assign axi_bready_o = 1'b1;

  a_ar_hold: assert property (
    @(posedge clk) disable iff (rst)
    axi_arvalid_o && !axi_arready_i |=> axi_arvalid_o && $stable(axi_araddr_o)
  );

  a_aw_hold: assert property (
    @(posedge clk) disable iff (rst)
    axi_awvalid_o && !axi_awready_i |=> axi_awvalid_o && $stable(axi_awaddr_o)
  );

  a_w_hold: assert property (
    @(posedge clk) disable iff (rst)
    axi_wvalid_o && !axi_wready_i |=> axi_wvalid_o && $stable(axi_wdata_o)
  );

  a_rresp_okay: assert property (
    @(posedge clk) disable iff (rst)
    axi_rvalid_i && axi_rready_o |-> axi_rresp_i == RESP_OKAY
  );

  a_bresp_okay: assert property (
    @(posedge clk) disable iff (rst)
    axi_bvalid_i && axi_bready_o |-> axi_bresp_i == RESP_OKAY
  );

endmodule

/* hdl/clint_timer.sv */
`timescale 1ns/1ps

module clint_timer #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic     clk,
  input  logic     rst,
  timer_rd_if.timer tmr
);
  import bus_pkg::*;

  logic [63:0]       mtime;
  logic [DATA_W-1:0] rdata_q;
  logic              rvalid_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime    <= '0;
      rvalid_q <= 1'b0;
    end
    else
    begin
      mtime    <= mtime + 64'd1;  // free running
      rvalid_q <= tmr.valid;
    end
  end

  // word select by address
  always_ff @(posedge clk)
  begin
    if (tmr.valid)
      rdata_q <= (tmr.addr == ADDR_W'(RTC_ADDR_HI)) ? mtime[63:32] : mtime[31:0];
  end

  assign tmr.rdata  = rdata_q;
  assign tmr.rvalid = rvalid_q;

endmodule

/* hdl/mem_bus_top.sv */
`timescale 1ns/1ps

module mem_bus_top #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic                clk,
  input  logic                rst,

  // instruction fetch
  input  logic [ADDR_W-1:0]   ifu_araddr_i,
  input  logic                ifu_arvalid_i,
  output logic [DATA_W-1:0]   ifu_rdata_o,
  output logic                ifu_rvalid_o,

  // load/store unit
  input  logic [ADDR_W-1:0]   lsu_araddr_i,
  input  logic                lsu_arvalid_i,
  input  logic [DATA_W/8-1:0] lsu_rstrb_i,
  output logic [DATA_W-1:0]   lsu_rdata_o,
  output logic                lsu_rvalid_o,
  input  logic [ADDR_W-1:0]   lsu_awaddr_i,
  input  logic                lsu_awvalid_i,
  input  logic [DATA_W-1:0]   lsu_wdata_i,
  input  logic [DATA_W/8-1:0] lsu_wstrb_i,
  output logic                lsu_wready_o,

  // AXI4 master, single beat
  output logic [ADDR_W-1:0]   axi_araddr_o,
  output bus_pkg::axi_size_t  axi_arsize_o,
  output logic                axi_arvalid_o,
  input  logic                axi_arready_i,
  output logic [3:0]          axi_arid_o,
  output logic [7:0]          axi_arlen_o,
  input  logic [63:0]         axi_rdata_i,
  input  bus_pkg::axi_resp_t  axi_rresp_i,
  input  logic                axi_rvalid_i,
  output logic                axi_rready_o,
  output logic [ADDR_W-1:0]   axi_awaddr_o,
  output bus_pkg::axi_size_t  axi_awsize_o,
  output logic                axi_awvalid_o,
  input  logic                axi_awready_i,
  output logic [3:0]          axi_awid_o,
  output logic [7:0]          axi_awlen_o,
  output logic [63:0]         axi_wdata_o,
  output logic [7:0]          axi_wstrb_o,
  output logic                axi_wlast_o,
  output logic                axi_wvalid_o,
  input  logic                axi_wready_i,
  input  bus_pkg::axi_resp_t  axi_bresp_i,
  input  logic                axi_bvalid_i,
  output logic                axi_bready_o
);

  mem_req_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) req ();
  timer_rd_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) tmr ();

  // port names match the instance names below
  bus_arbiter #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W)
  ) u_arbiter (
    .*
  );

  axi_master_port #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W)
  ) u_axi_port (
    .*
  );

  clint_timer #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W)
  ) u_timer (
    .clk (clk),
    .rst (rst),
    .tmr (tmr)
  );

endmodule

/* test/axi_mem_model.sv */
`timescale 1ns/1ps

module axi_mem_model (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] araddr_i,
  input  logic        arvalid_i,
  output logic        arready_o,
  output logic [63:0] rdata_o,
  output logic [1:0]  rresp_o,
  output logic        rvalid_o,
  input  logic        rready_i,
  input  logic [31:0] awaddr_i,
  input  logic        awvalid_i,
  output logic        awready_o,
  input  logic [63:0] wdata_i,
  input  logic [7:0]  wstrb_i,
  input  logic        wvalid_i,
  output logic        wready_o,
  output logic [1:0]  bresp_o,
  output logic        bvalid_o,
  input  logic        bready_i
);
  import bus_pkg::*;

  logic [63:0] mem [0:1023];  // 8 KiB, loaded by the testbench
  integer      seed = 30218;
  logic [1:0]  ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt;
  logic [31:0] raddr, waddr;
  logic [63:0] wdata_q;
  logic [7:0]  wstrb_q;
  logic        r_busy, aw_got, w_got, b_pend;

  function logic [1:0] rnd_delay();
    rnd_delay = 2'($random(seed));  // 0 to 3 cycles
  endfunction

  assign rresp_o = RESP_OKAY;
  assign bresp_o = RESP_OKAY;

  always @(posedge clk)
  begin
    if (rst)
    begin
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      r_busy    <= 1'b0;
      aw_got    <= 1'b0;
      w_got     <= 1'b0;
      b_pend    <= 1'b0;
      ar_cnt    <= rnd_delay();
      aw_cnt    <= rnd_delay();
      w_cnt     <= rnd_delay();
    end
    else
    begin
      // read address
      if (arready_o && arvalid_i)
      begin
        arready_o <= 1'b0;
        ar_cnt    <= rnd_delay();
        raddr     <= araddr_i;
        r_busy    <= 1'b1;
        r_cnt     <= rnd_delay();
      end
      else if (arvalid_i && !r_busy)
      begin
        if (ar_cnt == 2'd0)
          arready_o <= 1'b1;
        else
          ar_cnt <= ar_cnt - 2'd1;
      end
      // read data
      if (rvalid_o && rready_i)
        rvalid_o <= 1'b0;
      else if (r_busy && !(arready_o && arvalid_i))
      begin
        if (r_cnt == 2'd0)
        begin
          rvalid_o <= 1'b1;
          rdata_o  <= mem[raddr[12:3]];
          r_busy   <= 1'b0;
        end
        else
          r_cnt <= r_cnt - 2'd1;
      end
      // write address and data, either order
      if (awready_o && awvalid_i)
      begin
        awready_o <= 1'b0;
        aw_cnt    <= rnd_delay();
        waddr     <= awaddr_i;
        aw_got    <= 1'b1;
      end
      else if (awvalid_i && !aw_got)
      begin
        if (aw_cnt == 2'd0)
          awready_o <= 1'b1;
        else
          aw_cnt <= aw_cnt - 2'd1;
      end
      if (wready_o && wvalid_i)
      begin
        wready_o <= 1'b0;
        w_cnt    <= rnd_delay();
        wdata_q  <= wdata_i;
        wstrb_q  <= wstrb_i;
        w_got    <= 1'b1;
      end
      else if (wvalid_i && !w_got)
      begin
        if (w_cnt == 2'd0)
          wready_o <= 1'b1;
        else
          w_cnt <= w_cnt - 2'd1;
      end
      if (aw_got && w_got)
      begin
        for (int k = 0; k < 8; k++)
          if (wstrb_q[k])
            mem[waddr[12:3]][8*k +: 8] <= wdata_q[8*k +: 8];
        aw_got <= 1'b0;
        w_got  <= 1'b0;
        b_cnt  <= rnd_delay();
        b_pend <= 1'b1;
      end
      // b fires once the write is in and the delay ran out
      if (bvalid_o && bready_i)
        bvalid_o <= 1'b0;
      else if (b_pend)
      begin
        if (b_cnt == 2'd0)
        begin
          bvalid_o <= 1'b1;
          b_pend   <= 1'b0;
        end
        else
          b_cnt <= b_cnt - 2'd1;
      end
    end
  end

endmodule

/* test/tb_mem_bus_top.sv */
`timescale 1ns/1ps

module tb_mem_bus_top;
  import bus_pkg::*;

  logic        clk = 1'b0;
  logic        rst;
  logic [31:0] ifu_araddr_i, lsu_araddr_i, lsu_awaddr_i, lsu_wdata_i;
  logic        ifu_arvalid_i, lsu_arvalid_i, lsu_awvalid_i;
  logic [3:0]  lsu_rstrb_i, lsu_wstrb_i;
  logic [31:0] ifu_rdata_o, lsu_rdata_o;
  logic        ifu_rvalid_o, lsu_rvalid_o, lsu_wready_o;
  logic [31:0] axi_araddr_o, axi_awaddr_o;
  axi_size_t   axi_arsize_o, axi_awsize_o;
  logic        axi_arvalid_o, axi_arready_i, axi_rvalid_i, axi_rready_o;
  logic        axi_awvalid_o, axi_awready_i, axi_wvalid_o, axi_wready_i;
  logic        axi_wlast_o, axi_bvalid_i, axi_bready_o;
  logic [3:0]  axi_arid_o, axi_awid_o;
  logic [7:0]  axi_arlen_o, axi_awlen_o, axi_wstrb_o;
  logic [63:0] axi_rdata_i, axi_wdata_o;
  axi_resp_t   axi_rresp_i, axi_bresp_i;

  logic [7:0]  ref_mem [0:8191];
  integer      seed = 30218;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          wr_pulses = 0;
  int          ar_leak = 0;
  logic        timer_window = 1'b0;
  axi_size_t   exp_size;
  logic [7:0]  exp_strb;

  always #4 clk = ~clk;

  mem_bus_top #(.ADDR_W(32), .DATA_W(32)) dut (.*);

  axi_mem_model mem_model (
    .clk(clk), .rst(rst),
    .araddr_i(axi_araddr_o), .arvalid_i(axi_arvalid_o), .arready_o(axi_arready_i),
    .rdata_o(axi_rdata_i), .rresp_o(axi_rresp_i), .rvalid_o(axi_rvalid_i),
    .rready_i(axi_rready_o),
    .awaddr_i(axi_awaddr_o), .awvalid_i(axi_awvalid_o), .awready_o(axi_awready_i),
    .wdata_i(axi_wdata_o), .wstrb_i(axi_wstrb_o), .wvalid_i(axi_wvalid_o),
    .wready_o(axi_wready_i),
    .bresp_o(axi_bresp_i), .bvalid_o(axi_bvalid_i), .bready_i(axi_bready_o)
  );

  function automatic logic [31:0] fill_word(logic [31:0] a);
    fill_word = a * 32'h9e37_79b1 + 32'h1234_5677;
  endfunction

  // expected load: aligned word from the byte mirror
  function automatic logic [31:0] ref_load(logic [31:0] a);
    logic [12:0] b;
    b = {a[12:2], 2'b00};
    ref_load = {ref_mem[b+3], ref_mem[b+2], ref_mem[b+1], ref_mem[b]};
  endfunction

  function automatic logic [7:0] ref_strb(logic [3:0] s, logic [31:0] a);
    logic [3:0] sh;
    sh = s << a[1:0];
    ref_strb = a[2] ? {sh, 4'h0} : {4'h0, sh};
  endfunction

  function automatic axi_size_t ref_size(logic [3:0] s);
    ref_size = (s == 4'hf) ? SIZE_W : (s == 4'h3) ? SIZE_H : SIZE_B;
  endfunction

  task automatic check_data(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_size(string name, axi_size_t got, axi_size_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_strb(logic [7:0] got, logic [7:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR axi_wstrb_o got %h expected %h", got, exp);
    end
  endtask

  // ids, lengths, last and ready levels
  task automatic check_ctrl(string name, logic [7:0] got, logic [7:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  // compare at the AW handshake
  always @(posedge clk)
  begin
    if (!rst && axi_awvalid_o && axi_awready_i)
    begin
      check_size("axi_awsize_o", axi_awsize_o, exp_size);
      check_strb(axi_wstrb_o, exp_strb);
      check_ctrl("axi_awid_o", {4'h0, axi_awid_o}, 8'h00);
      check_ctrl("axi_awlen_o", axi_awlen_o, 8'h00);
    end
    if (!rst && axi_wvalid_o && axi_wready_i)
      check_ctrl("axi_wlast_o", {7'h00, axi_wlast_o}, 8'h01);
    if (!rst && axi_arvalid_o && axi_arready_i)
    begin
      check_size("axi_arsize_o", axi_arsize_o, ref_size(4'hf));  // fetches and loads are words
      check_ctrl("axi_arid_o", {4'h0, axi_arid_o}, 8'h00);
      check_ctrl("axi_arlen_o", axi_arlen_o, 8'h00);
    end
    if (!rst && axi_rvalid_i)
      check_ctrl("axi_rready_o", {7'h00, axi_rready_o}, 8'h01);
    if (!rst && axi_bvalid_i)
      check_ctrl("axi_bready_o", {7'h00, axi_bready_o}, 8'h01);
    if (!rst && lsu_wready_o)
      wr_pulses++;
    if (timer_window && axi_arvalid_o)
      ar_leak++;
  end

  task automatic do_fetch(logic [31:0] a, output logic [31:0] d);
    int n;
    ifu_araddr_i  = a;
    ifu_arvalid_i = 1'b1;
    n = 0;
    do
    begin
      @(negedge clk);
      n++;
    end
    while (n < 200 && !ifu_rvalid_o);
    if (!ifu_rvalid_o)
    begin
      errors++;
      $display("fetch at %h timed out waiting for ifu_rvalid_o", a);
    end
    d = ifu_rdata_o;
    ifu_arvalid_i = 1'b0;
  endtask

  task automatic do_load(logic [31:0] a, output logic [31:0] d, output int lat);
    lsu_araddr_i  = a;
    lsu_rstrb_i   = 4'hf;
    lsu_arvalid_i = 1'b1;
    lat = 0;
    do
    begin
      @(negedge clk);
      lat++;
    end
    while (lat < 200 && !lsu_rvalid_o);
    if (!lsu_rvalid_o)
    begin
      errors++;
      $display("load at %h timed out waiting for lsu_rvalid_o", a);
    end
    d = lsu_rdata_o;
    lsu_arvalid_i = 1'b0;
  endtask

  task automatic do_store(logic [31:0] a, logic [31:0] d, logic [3:0] s);
    int n;
    exp_size = ref_size(s);
    exp_strb = ref_strb(s, a);
    for (int k = 0; k < 4; k++)
      if (s[k])
        ref_mem[a[12:0] + k] = d[8*k +: 8];
    lsu_awaddr_i  = a;
    lsu_wdata_i   = d;
    lsu_wstrb_i   = s;
    lsu_awvalid_i = 1'b1;
    n = 0;
    do
    begin
      @(negedge clk);
      n++;
    end
    while (n < 200 && !lsu_wready_o);
    if (!lsu_wready_o)
    begin
      errors++;
      $display("store at %h timed out waiting for lsu_wready_o", a);
    end
    lsu_awvalid_i = 1'b0;
  endtask

  task automatic load_and_check(logic [31:0] a);
    logic [31:0] d;
    int          lat;
    do_load(a, d, lat);
    check_data("lsu_rdata_o", d, ref_load(a));
  endtask

  task automatic report_test(string name, int err_before);
    tests++;
    $display("test %-12s %s", name, (errors == err_before) ? "ok" : "failed");
  endtask

  initial
  begin
    logic [31:0] d, t1, t2;
    logic [31:0] r, a;
    int          e0, lat, n;
    bit          ifu_seen, lsu_seen, lsu_first;
    rst = 1'b1;
    {ifu_arvalid_i, lsu_arvalid_i, lsu_awvalid_i} = 3'b000;
    {ifu_araddr_i, lsu_araddr_i, lsu_awaddr_i, lsu_wdata_i} = '0;
    lsu_rstrb_i = 4'hf;
    lsu_wstrb_i = 4'hf;
    for (int i = 0; i < 1024; i++)
    begin
      mem_model.mem[i] = {fill_word(8*i + 4), fill_word(8*i)};
      for (int k = 0; k < 4; k++)
      begin
        ref_mem[8*i + k]     = fill_word(8*i) >> (8*k);
        ref_mem[8*i + 4 + k] = fill_word(8*i + 4) >> (8*k);
      end
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    e0 = errors;
    for (int i = 0; i < 6; i++)
    begin
      do_fetch(32'h100 + 4*i, d);  // lower and upper lanes
      check_data("ifu_rdata_o", d, ref_load(32'h100 + 4*i));
    end
    report_test("ifu_fetch", e0);

    e0 = errors;
    n = wr_pulses;
    do_store(32'h200, 32'hdead_beef, 4'hf);
    do_store(32'h206, 32'h0000_a55a, 4'h3);
    do_store(32'h209, 32'h0000_007e, 4'h1);
    do_store(32'h20f, 32'h0000_00c3, 4'h1);
    @(negedge clk);
    check_data("wready_pulses", wr_pulses - n, 4);
    load_and_check(32'h200);
    load_and_check(32'h204);
    load_and_check(32'h208);
    load_and_check(32'h20c);
    report_test("lsu_store", e0);

    // both clients raise in one cycle
    e0 = errors;
    ifu_araddr_i  = 32'h300;
    lsu_araddr_i  = 32'h344;
    lsu_rstrb_i   = 4'hf;
    ifu_arvalid_i = 1'b1;
    lsu_arvalid_i = 1'b1;
    ifu_seen = 1'b0;
    lsu_seen = 1'b0;
    lsu_first = 1'b0;
    for (n = 0; n < 200 && !(ifu_seen && lsu_seen); n++)
    begin
      @(negedge clk);
      if (lsu_rvalid_o)
      begin
        lsu_first = !ifu_seen;
        lsu_seen = 1'b1;
        lsu_arvalid_i = 1'b0;
        check_data("lsu_rdata_o", lsu_rdata_o, ref_load(32'h344));
      end
      if (ifu_rvalid_o)
      begin
        ifu_seen = 1'b1;
        ifu_arvalid_i = 1'b0;
        check_data("ifu_rdata_o", ifu_rdata_o, ref_load(32'h300));
      end
    end
    if (!(ifu_seen && lsu_seen))
    begin
      errors++;
      $display("priority test timed out before both clients were answered");
    end
    else if (!lsu_first)
    begin
      errors++;
      $display("the IFU was answered before the LSU");
    end
    ifu_arvalid_i = 1'b0;
    lsu_arvalid_i = 1'b0;
    report_test("priority", e0);

    e0 = errors;
    timer_window = 1'b1;
    @(negedge clk);  // arbiter back in idle
    do_load(RTC_ADDR_HI, d, lat);
    check_data("lsu_rdata_o", d, 32'h0);
    check_data("timer_latency", lat, 2);
    @(negedge clk);
    do_load(RTC_ADDR_LO, t1, lat);
    check_data("timer_latency", lat, 2);
    repeat (3) @(negedge clk);
    do_load(RTC_ADDR_LO, t2, lat);
    check_data("timer_latency", lat, 2);
    timer_window = 1'b0;
    if (t2 <= t1)
    begin
      errors++;
      $display("mtime did not increase between two reads: %h then %h", t1, t2);
    end
    check_data("ar_during_timer", ar_leak, 0);
    report_test("timer", e0);

    e0 = errors;
    for (int i = 0; i < 200; i++)
    begin
      r = $random(seed);
      a = {19'h0, r[12:2], 2'b00};
      case (r[15:14])
        2'd0:
          load_and_check(a);
        2'd1:
          do_store(a, $random(seed), 4'hf);
        2'd2:
          do_store({a[31:2], r[1], 1'b0}, $random(seed), 4'h3);
        default:
          do_store({a[31:2], r[1:0]}, $random(seed), 4'h1);
      endcase
      if (r[15:14] != 2'd0 && r[16])
        load_and_check(a);
    end
    report_test("soak", e0);

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

/* mem_bus_top.f */
hdl/bus_pkg.sv
hdl/mem_req_if.sv
hdl/timer_rd_if.sv
hdl/bus_arbiter.sv
hdl/axi_master_port.sv
hdl/clint_timer.sv
hdl/mem_bus_top.sv
test/axi_mem_model.sv
test/tb_mem_bus_top.sv
